//--- hw/ipv4_pkg.sv
package ipv4_pkg;

  localparam int          IPV4_HDR_LEN   = 20;       // Header bytes, no options
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

  typedef logic [3:0][7:0] ipv4_t;
  typedef logic [5:0][7:0] mac_addr_t;

  localparam ipv4_t IPV4_BROADCAST = '1;

  // Header fields in wire order, first byte at the MSB
  typedef struct packed {
    logic [3:0]  ver;
    logic [3:0]  ihl;
    logic [7:0]  qos;
    logic [15:0] length;   // Total length incl. header
    logic [15:0] id;
    logic        rsv;      // Reserved flag, always 0
    logic        df;
    logic        mf;
    logic [12:0] fo;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] chsum;
    ipv4_t       src_ip;
    ipv4_t       dst_ip;
  } ipv4_hdr_t;

  // Same 160 bits seen as fields or as bytes, b[19] goes on the wire first
  typedef union packed {
    ipv4_hdr_t                    f;
    logic [IPV4_HDR_LEN-1:0][7:0] b;
  } ipv4_hdr_u;

  typedef struct packed {
    logic [7:0]  dat;
    logic        val;
    logic        sof;
    logic        eof;
    logic        err;
    logic [15:0] ethertype;
  } mac_rx_t;

  typedef struct packed {
    logic [7:0]  dat;
    logic        val;
    logic        sof;
    logic        eof;
    mac_addr_t   dst_mac;
    mac_addr_t   src_mac;
    logic [15:0] ethertype;
  } mac_tx_t;

  typedef struct packed {
    logic [7:0]  dat;
    logic        val;
    logic        sof;
    logic        eof;
    logic [15:0] payload_length;
    ipv4_hdr_t   hdr;
  } ipv4_rx_t;

  typedef struct packed {
    logic      rdy;
    logic      broadcast;
    ipv4_hdr_t hdr;        // chsum field is not used
  } tx_src_t;

  typedef struct packed {
    ipv4_t     ipv4_addr;
    mac_addr_t mac_addr;
  } dev_t;

  // Ones' complement add, carries above bit 15 are folded back lazily
  function automatic logic [18:0] chsum_add(input logic [18:0] acc, input logic [15:0] word);
    return {3'b000, acc[15:0]} + acc[18:16] + word;
  endfunction

  function automatic logic [15:0] chsum_fold(input logic [18:0] acc);
    logic [16:0] s;
    s = acc[15:0] + acc[18:16];
    return s[15:0] + s[16];
  endfunction

endpackage

//--- hw/ipv4_rx_parser.sv
module ipv4_rx_parser
  import ipv4_pkg::*;
(
  input  logic     clk,
  input  logic     fsm_rst,
  input  mac_rx_t  rx,
  input  dev_t     dev,
  output ipv4_rx_t rx_out
);

  logic [15:0] byte_cnt;   // Index of the next byte in the frame
  logic [15:0] idx;        // Index of the byte on rx now
  logic        in_hdr;
  logic        accept;
  logic [7:0]  sum_hi;
  logic [18:0] sum;
  logic [18:0] sum_nxt;
  ipv4_hdr_u   hdr;
  ipv4_hdr_u   hdr_nxt;
  logic        hdr_last;
  logic        dst_match;
  logic        hdr_good;

  assign idx     = rx.sof ? 16'd0 : byte_cnt;
  assign hdr_nxt = {hdr.b[IPV4_HDR_LEN-2:0], rx.dat};
  assign sum_nxt = chsum_add(sum, {sum_hi, rx.dat});

  assign hdr_last  = rx.val && in_hdr && (idx == 16'(IPV4_HDR_LEN - 1));
  assign dst_match = (hdr_nxt.f.dst_ip == dev.ipv4_addr) ||
                     (hdr_nxt.f.dst_ip == IPV4_BROADCAST);
  // Whole header incl. chsum field must fold to all ones
  assign hdr_good  = (hdr_nxt.f.ihl == 4'd5) &&
                     (hdr_nxt.f.length > 16'(IPV4_HDR_LEN)) &&
                     (chsum_fold(sum_nxt) == 16'hffff) && dst_match;

  always_ff @(posedge clk) begin
    rx_out.dat <= rx.dat; // One cycle through
    if (rx.val) begin
      hdr <= hdr_nxt;
      if (rx.sof) begin
        sum <= '0;
      end else if (idx[0]) begin
        sum <= sum_nxt; // Odd byte closes a 16-bit word
      end
      if (!idx[0]) sum_hi <= rx.dat;
    end
    if (hdr_last && hdr_good) begin
      rx_out.hdr            <= hdr_nxt.f;
      rx_out.payload_length <= hdr_nxt.f.length - 16'(IPV4_HDR_LEN);
    end

    if (fsm_rst) begin
      byte_cnt   <= '0;
      in_hdr     <= 1'b0;
      accept     <= 1'b0;
      rx_out.val <= 1'b0;
      rx_out.sof <= 1'b0;
      rx_out.eof <= 1'b0;
    end else begin
      rx_out.val <= 1'b0;
      rx_out.sof <= 1'b0;
      rx_out.eof <= 1'b0;
      if (rx.val) byte_cnt <= idx + 16'd1;
      if (rx.err) begin
        in_hdr <= 1'b0; // Drop the rest, no eof
        accept <= 1'b0;
      end else if (rx.val) begin
        if (rx.sof) begin
          in_hdr <= (rx.ethertype == ETHERTYPE_IPV4);
          accept <= 1'b0;
        end else if (hdr_last) begin
          in_hdr <= 1'b0;
          accept <= hdr_good;
        end else if (accept) begin
          rx_out.val <= 1'b1;
          rx_out.sof <= (idx == 16'(IPV4_HDR_LEN));
          rx_out.eof <= (idx == rx_out.hdr.length - 16'd1);
          // Ethernet padding after the total length is not forwarded
          if (idx == rx_out.hdr.length - 16'd1) accept <= 1'b0;
        end
      end
    end
  end

endmodule

//--- hw/ipv4_tx_arbiter.sv
module ipv4_tx_arbiter #(
  parameter int N_SRC = 3
) (
  input  logic             clk,
  input  logic             fsm_rst,
  input  logic [N_SRC-1:0] src_rdy,
  input  logic             done,
  output logic [N_SRC-1:0] grant,
  output logic             busy
);

  logic [N_SRC-1:0] pick;

  // Highest ready index wins
  always_comb begin
    pick = '0;
    for (int i = 0; i < N_SRC; i++) begin
      if (src_rdy[i]) begin
        pick    = '0;
        pick[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      grant <= '0;
      busy  <= 1'b0;
    end else if (done) begin
      grant <= '0; // Packet sent or aborted
      busy  <= 1'b0;
    end else if (!busy && (|pick)) begin
      grant <= pick; // Locked until done
      busy  <= 1'b1;
    end
  end

endmodule

//--- hw/ipv4_hdr_builder.sv
module ipv4_hdr_builder
  import ipv4_pkg::*;
#(
  parameter int N_SRC = 3
) (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic    [N_SRC-1:0] grant,
  input  tx_src_t [N_SRC-1:0] src,
  input  logic                arp_val,
  input  logic                arp_err,
  output ipv4_t               arp_req,
  output ipv4_hdr_u           hdr,
  output logic                broadcast,
  output logic                hdr_ok,
  output logic                abort
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_SUM  = 2'd1;
  localparam logic [1:0] S_ARP  = 2'd2;
  localparam logic [1:0] S_SENT = 2'd3;

  logic [1:0]  state;
  logic [3:0]  word_cnt;
  logic [15:0] word;
  logic [18:0] sum;
  logic [18:0] sum_nxt;
  logic        err_seen; // ARP may fail while summing
  tx_src_t     sel;

  always_comb begin
    sel = '0;
    for (int i = 0; i < N_SRC; i++) begin
      if (grant[i]) sel = src[i];
    end
  end

  // Word k is bytes 2k and 2k+1 of the header
  assign word    = {hdr.b[IPV4_HDR_LEN-1-2*word_cnt], hdr.b[IPV4_HDR_LEN-2-2*word_cnt]};
  assign sum_nxt = chsum_add(sum, word);
  assign arp_req = hdr.f.dst_ip;

  always_ff @(posedge clk) begin
    if (state == S_IDLE) begin
      hdr.f       <= sel.hdr;
      hdr.f.ver   <= 4'd4;
      hdr.f.ihl   <= 4'd5;
      hdr.f.rsv   <= 1'b0;
      hdr.f.chsum <= '0; // Summed as zero
      broadcast   <= sel.broadcast;
      sum         <= '0;
    end
    if (state == S_SUM) begin
      sum <= sum_nxt;
      if (word_cnt == 4'd9) hdr.f.chsum <= ~chsum_fold(sum_nxt);
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= S_IDLE;
      word_cnt <= '0;
      err_seen <= 1'b0;
      hdr_ok   <= 1'b0;
      abort    <= 1'b0;
    end else begin
      hdr_ok <= 1'b0;
      abort  <= 1'b0;
      case (state)
        S_IDLE: begin
          if (|grant) begin
            state    <= S_SUM;
            word_cnt <= '0;
            err_seen <= 1'b0;
          end
        end
        S_SUM: begin
          word_cnt <= word_cnt + 4'd1;
          if (arp_err) err_seen <= 1'b1;
          if (word_cnt == 4'd9) state <= S_ARP;
        end
        S_ARP: begin
          if (broadcast || arp_val) begin
            hdr_ok <= 1'b1;
            state  <= S_SENT;
          end else if (arp_err || err_seen) begin
            abort <= 1'b1;
            state <= S_SENT;
          end
        end
        default: begin
          if (!(|grant)) state <= S_IDLE; // Wait for done to clear grant
        end
      endcase
    end
  end

endmodule

//--- hw/ipv4_tx_framer.sv
module ipv4_tx_framer
  import ipv4_pkg::*;
#(
  parameter int N_SRC = 3
) (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  ipv4_hdr_u             hdr,
  input  logic                  hdr_ok,
  input  logic                  broadcast,
  input  mac_addr_t             arp_mac,
  input  dev_t                  dev,
  input  logic [N_SRC-1:0]      grant,
  input  logic                  abort,
  input  logic [N_SRC-1:0][7:0] src_dat,
  input  logic [N_SRC-1:0]      src_val,
  input  logic [N_SRC-1:0]      src_eof,
  output logic [N_SRC-1:0]      src_req,
  output logic [N_SRC-1:0]      src_done,
  output logic                  done,
  output mac_tx_t               tx
);

  ipv4_hdr_u  sh;        // Header shift register
  logic [4:0] hdr_cnt;
  logic       hdr_phase;
  logic       pay_phase;
  logic [7:0] sel_dat;
  logic       sel_val;
  logic       sel_eof;
  logic [7:0] tx_dat;
  logic       tx_val;
  logic       tx_sof;
  logic       tx_eof;
  mac_addr_t  peer_mac;

  always_comb begin
    sel_dat = '0;
    sel_val = 1'b0;
    sel_eof = 1'b0;
    for (int i = 0; i < N_SRC; i++) begin
      if (grant[i]) begin
        sel_dat = src_dat[i];
        sel_val = src_val[i];
        sel_eof = src_eof[i];
      end
    end
  end

  assign tx = '{dat: tx_dat, val: tx_val, sof: tx_sof, eof: tx_eof,
                dst_mac: peer_mac, src_mac: dev.mac_addr, ethertype: ETHERTYPE_IPV4};

  always_ff @(posedge clk) begin
    if (hdr_ok) begin
      sh.b     <= {hdr.b[IPV4_HDR_LEN-2:0], 8'h00};
      tx_dat   <= hdr.b[IPV4_HDR_LEN-1];
      peer_mac <= broadcast ? '1 : arp_mac;
    end else if (hdr_phase) begin
      sh.b   <= {sh.b[IPV4_HDR_LEN-2:0], 8'h00};
      tx_dat <= sh.b[IPV4_HDR_LEN-1];
    end else begin
      tx_dat <= sel_dat; // Payload register stage
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      hdr_cnt   <= '0;
      hdr_phase <= 1'b0;
      pay_phase <= 1'b0;
      tx_val    <= 1'b0;
      tx_sof    <= 1'b0;
      tx_eof    <= 1'b0;
      src_req   <= '0;
      src_done  <= '0;
      done      <= 1'b0;
    end else begin
      tx_sof   <= 1'b0;
      tx_eof   <= 1'b0;
      done     <= tx_eof || abort;
      src_done <= (tx_eof || abort) ? grant : '0;
      if (hdr_ok) begin
        hdr_phase <= 1'b1;
        hdr_cnt   <= 5'd1;
        tx_val    <= 1'b1;
        tx_sof    <= 1'b1;
      end else if (hdr_phase) begin
        hdr_cnt <= hdr_cnt + 5'd1;
        // Request goes out with header byte 18, payload lands right after byte 19
        if (hdr_cnt == 5'(IPV4_HDR_LEN - 2)) src_req <= grant;
        if (hdr_cnt == 5'(IPV4_HDR_LEN - 1)) begin
          hdr_phase <= 1'b0;
          pay_phase <= 1'b1;
        end
      end else if (pay_phase) begin
        tx_val <= sel_val;
        tx_eof <= sel_val && sel_eof;
        if (sel_val && sel_eof) begin
          pay_phase <= 1'b0;
          src_req   <= '0;
        end
      end else begin
        tx_val <= 1'b0;
      end
    end
  end

endmodule

//--- hw/ipv4_core.sv
module ipv4_core
  import ipv4_pkg::*;
#(
  parameter int N_SRC = 3
) (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  mac_rx_t               rx,
  output ipv4_rx_t              rx_out,
  input  tx_src_t [N_SRC-1:0]   src,
  input  logic [N_SRC-1:0][7:0] src_dat,
  input  logic [N_SRC-1:0]      src_val,
  input  logic [N_SRC-1:0]      src_eof,
  output logic [N_SRC-1:0]      src_req,
  output logic [N_SRC-1:0]      src_done,
  output mac_tx_t               tx,
  output ipv4_t                 arp_req,  // Lookup key to ARP table
  input  mac_addr_t             arp_mac,
  input  logic                  arp_val,
  input  logic                  arp_err,  // No entry or ARP timeout
  input  dev_t                  dev
);

  logic [N_SRC-1:0] src_rdy;
  logic [N_SRC-1:0] grant;
  logic             tx_done;
  logic             hdr_ok;
  logic             abort;
  logic             broadcast;
  ipv4_hdr_u        hdr;

  for (genvar i = 0; i < N_SRC; i++) begin : g_rdy
    assign src_rdy[i] = src[i].rdy;
  end

  ipv4_rx_parser u_rx_parser (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .rx      (rx),
    .dev     (dev),
    .rx_out  (rx_out)
  );

  ipv4_tx_arbiter #(.N_SRC(N_SRC)) u_tx_arbiter (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .src_rdy (src_rdy),
    .done    (tx_done),
    .grant   (grant),
    .busy    ()
  );

  ipv4_hdr_builder #(.N_SRC(N_SRC)) u_hdr_builder (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .grant     (grant),
    .src       (src),
    .arp_val   (arp_val),
    .arp_err   (arp_err),
    .arp_req   (arp_req),
    .hdr       (hdr),
    .broadcast (broadcast),
    .hdr_ok    (hdr_ok),
    .abort     (abort)
  );

  ipv4_tx_framer #(.N_SRC(N_SRC)) u_tx_framer (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .hdr       (hdr),
    .hdr_ok    (hdr_ok),
    .broadcast (broadcast),
    .arp_mac   (arp_mac),
    .dev       (dev),
    .grant     (grant),
    .abort     (abort),
    .src_dat   (src_dat),
    .src_val   (src_val),
    .src_eof   (src_eof),
    .src_req   (src_req),
    .src_done  (src_done),
    .done      (tx_done),
    .tx        (tx)
  );

endmodule

//--- testbench/ipv4_core_props.sv
module ipv4_core_props
  import ipv4_pkg::*;
#(
  parameter int N_SRC = 3
) (
  input logic             clk,
  input logic             fsm_rst,
  input logic [N_SRC-1:0] grant,
  input logic [N_SRC-1:0] src_req,
  input mac_tx_t          tx
);

  a_grant_onehot: assert property (@(posedge clk) disable iff (fsm_rst)
    $onehot0(grant))
    else $error("grant is not one-hot");

  // No gap inside a frame
  a_val_gapless: assert property (@(posedge clk) disable iff (fsm_rst)
    (tx.val && !tx.eof) |=> tx.val)
    else $error("tx.val dropped before tx.eof");

  a_eof_ends: assert property (@(posedge clk) disable iff (fsm_rst)
    tx.eof |=> !tx.val)
    else $error("tx.val still high after tx.eof");

  a_req_granted: assert property (@(posedge clk) disable iff (fsm_rst)
    (src_req & ~grant) == '0)
    else $error("src_req raised for a source without grant");

endmodule

bind ipv4_tx_framer ipv4_core_props #(.N_SRC(N_SRC)) u_props (
  .clk     (clk),
  .fsm_rst (fsm_rst),
  .grant   (grant),
  .src_req (src_req),
  .tx      (tx)
);

//--- testbench/tb_ipv4_core.sv
module tb_ipv4_core
  import ipv4_pkg::*;
;

  localparam int          N_SRC          = 3;
  localparam int          N_ROWS         = 9;
  localparam int          TIMEOUT_CYCLES = N_ROWS * 200;
  localparam logic [31:0] DEV_IP         = 32'h0a000002;
  localparam logic [47:0] DEV_MAC        = 48'h020000000002;
  localparam logic [47:0] ARP_MAC        = 48'h0a1b2c3d4e5f;
  localparam logic [31:0] PEER_IP        = 32'h0a000005;
  localparam logic [31:0] FOREIGN_IP     = 32'h0a000063;
  localparam logic [31:0] BCAST_IP       = 32'hffffffff;

  typedef struct packed {
    logic        dir_tx;    // 0 receive, 1 transmit
    logic [2:0]  srcs;      // Sources made ready together
    logic [31:0] dst;
    logic [7:0]  len;       // Payload bytes
    logic        bcast;
    logic        bad_sum;
    logic [15:0] etype;
    logic [1:0]  arp;       // 0 silent, 1 answers, 2 fails
    logic        expect_ok; // Accepted or sent
  } row_t;

  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
  } frame_t;

  logic                  clk;
  logic                  fsm_rst;
  mac_rx_t               rx;
  ipv4_rx_t              rx_out;
  tx_src_t [N_SRC-1:0]   src;
  logic [N_SRC-1:0][7:0] src_dat;
  logic [N_SRC-1:0]      src_val;
  logic [N_SRC-1:0]      src_eof;
  logic [N_SRC-1:0]      src_req;
  logic [N_SRC-1:0]      src_done;
  mac_tx_t               tx;
  ipv4_t                 arp_req;
  mac_addr_t             arp_mac;
  logic                  arp_val;
  logic                  arp_err;
  dev_t                  dev;

  row_t        rows [N_ROWS];
  int          seed = 32'h0151e391;
  int          errors;
  int          checks;
  int          cycles;
  logic [7:0]  rx_exp [$];     // Payload still due on rx_out
  logic [15:0] rx_len_exp;
  logic [31:0] rx_dst_exp;
  logic        rx_first;
  int          rx_done_cnt;
  logic [9:0]  tx_exp [$];     // {sof, eof, byte} still due on tx
  frame_t      frame_q [$];
  logic [7:0]  pay [N_SRC][64];
  int          pay_len [N_SRC];
  int          pay_pos [N_SRC];
  logic        req_seen [N_SRC];
  logic [7:0]  rx_byte;
  logic [9:0]  tx_item;
  frame_t      tx_frame;

  ipv4_core #(.N_SRC(N_SRC)) DUT (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .rx       (rx),
    .rx_out   (rx_out),
    .src      (src),
    .src_dat  (src_dat),
    .src_val  (src_val),
    .src_eof  (src_eof),
    .src_req  (src_req),
    .src_done (src_done),
    .tx       (tx),
    .arp_req  (arp_req),
    .arp_mac  (arp_mac),
    .arp_val  (arp_val),
    .arp_err  (arp_err),
    .dev      (dev)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  task automatic report_and_finish(input logic timed_out);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  endtask

  // Ones' complement sum of ten words with end-around carry
  function automatic logic [15:0] header_checksum(input logic [159:0] h);
    logic [31:0] acc;
    acc = '0;
    for (int k = 0; k < 10; k++) acc = acc + {16'h0000, h[159-16*k -: 16]};
    while (acc[31:16] != 16'h0000) acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
    return ~acc[15:0];
  endfunction

  // Byte 0 sits at bits 159:152 with DF set, TTL 64 and UDP
  function automatic logic [159:0] make_hdr(input logic [15:0] total, input logic [15:0] id,
                                             input logic [31:0] sip, input logic [31:0] dip);
    logic [159:0] h;
    h = {8'h45, 8'h00, total, id, 16'h4000, 8'd64, 8'd17, 16'h0000, sip, dip};
    h[79:64] = header_checksum(h);
    return h;
  endfunction

  task automatic run_rx(input int r);
    row_t         row;
    logic [159:0] h;
    logic [7:0]   frame [$];
    logic [7:0]   b;
    int           done_before;
    row = rows[r];
    h = make_hdr(16'(20 + int'(row.len)), {8'(r), 8'h00}, 32'h0a000009, row.dst);
    if (row.bad_sum) h[64] = ~h[64];
    rx_len_exp = 16'(row.len);
    rx_dst_exp = row.dst;
    rx_first   = 1'b1;
    for (int k = 0; k < 20; k++) frame.push_back(h[159-8*k -: 8]);
    for (int k = 0; k < int'(row.len); k++) begin
      b = 8'($random(seed));
      frame.push_back(b);
      if (row.expect_ok) rx_exp.push_back(b);
    end
    done_before = rx_done_cnt;
    for (int k = 0; k < frame.size(); k++) begin
      @(posedge clk);
      #1;
      rx.dat       = frame[k];
      rx.val       = 1'b1;
      rx.sof       = (k == 0);
      rx.eof       = (k == frame.size() - 1);
      rx.ethertype = row.etype;
    end
    @(posedge clk);
    #1;
    rx.val = 1'b0;
    rx.sof = 1'b0;
    rx.eof = 1'b0;
    if (row.expect_ok) begin
      while (rx_done_cnt == done_before) begin
        @(posedge clk);
        #1;
      end
    end else begin
      repeat (3) @(posedge clk); // Output latency is one cycle
      #1;
    end
  endtask

  task automatic run_tx(input int r);
    row_t         row;
    logic [159:0] h;
    int           n;
    int           done_cnt;
    row = rows[r];
    done_cnt = 0;
    // Highest index is granted first so its frame is queued first
    for (int i = N_SRC - 1; i >= 0; i--) begin
      if (row.srcs[i]) begin
        n = int'(row.len) + i;
        h = make_hdr(16'(20 + n), {8'(r), 8'(i)}, DEV_IP, row.dst);
        for (int k = 0; k < n; k++) pay[i][k] = 8'($random(seed));
        pay_len[i]  = n;
        pay_pos[i]  = 0;
        req_seen[i] = 1'b0;
        if (row.expect_ok) begin
          for (int k = 0; k < 20; k++) tx_exp.push_back({k == 0, 1'b0, h[159-8*k -: 8]});
          for (int k = 0; k < n; k++) tx_exp.push_back({1'b0, k == n - 1, pay[i][k]});
          frame_q.push_back('{mac: row.bcast ? '1 : ARP_MAC, ip: row.dst});
        end
        h[79:64]         = 16'hbeef; // DUT fills in its own checksum
        src[i].hdr       = h;
        src[i].broadcast = row.bcast;
        src[i].rdy       = 1'b1;
      end
    end
    while (done_cnt < $countones(row.srcs)) begin
      @(posedge clk);
      #1;
      arp_val = (row.arp == 2'd1) && (arp_req === row.dst); // ARP table lookup
      arp_err = (row.arp == 2'd2) && (arp_req === row.dst);
      for (int i = 0; i < N_SRC; i++) begin
        src_val[i] = 1'b0;
        src_eof[i] = 1'b0;
        if (src_done[i]) begin
          check_eq("arp_req", row.dst, arp_req);
          src[i].rdy  = 1'b0;
          req_seen[i] = 1'b0;
          done_cnt++;
        end else if (src_req[i]) begin
          // First byte one cycle after req is seen
          if (req_seen[i] && pay_pos[i] < pay_len[i]) begin
            src_dat[i] = pay[i][pay_pos[i]];
            src_val[i] = 1'b1;
            src_eof[i] = (pay_pos[i] == pay_len[i] - 1);
            pay_pos[i]++;
          end
          req_seen[i] = 1'b1;
        end
      end
    end
    arp_val = 1'b0;
    arp_err = 1'b0;
    check_true(tx_exp.size() == 0, "frame bytes missing on tx");
  endtask

  always @(posedge clk) begin
    if (!fsm_rst && rx_out.val) begin
      check_true(rx_exp.size() != 0, "rx_out.val high with no payload expected");
      if (rx_exp.size() != 0) begin
        rx_byte = rx_exp.pop_front();
        check_eq("rx_out.dat", rx_byte, rx_out.dat);
        check_eq("rx_out.sof", rx_first, rx_out.sof);
        check_eq("rx_out.eof", rx_exp.size() == 0, rx_out.eof);
        check_eq("rx_out.payload_length", rx_len_exp, rx_out.payload_length);
        check_eq("rx_out.hdr.dst_ip", rx_dst_exp, rx_out.hdr.dst_ip);
        rx_first = 1'b0;
        if (rx_exp.size() == 0) rx_done_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    if (!fsm_rst && tx.val) begin
      check_true(tx_exp.size() != 0, "tx.val high with no frame expected");
      if (tx_exp.size() != 0) begin
        tx_item = tx_exp.pop_front();
        check_eq("tx.dat", tx_item[7:0], tx.dat);
        check_eq("tx.sof", tx_item[9], tx.sof);
        check_eq("tx.eof", tx_item[8], tx.eof);
        if (tx_item[9]) begin
          tx_frame = frame_q.pop_front();
          check_eq("tx.dst_mac", tx_frame.mac, tx.dst_mac);
          check_eq("tx.src_mac", DEV_MAC, tx.src_mac);
          check_eq("tx.ethertype", 16'h0800, tx.ethertype);
          check_eq("arp_req", tx_frame.ip, arp_req);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      report_and_finish(1'b1);
    end
  end

  initial begin
    fsm_rst = 1'b1;
    rx      = '0;
    src     = '0;
    src_dat = '0;
    src_val = '0;
    src_eof = '0;
    arp_mac = ARP_MAC;
    arp_val = 1'b0;
    arp_err = 1'b0;
    dev     = '{ipv4_addr: DEV_IP, mac_addr: DEV_MAC};
    //          dir   srcs    dst         len    bc    bad   etype     arp   ok
    rows[0] = '{1'b0, 3'b000, DEV_IP,     8'd12, 1'b0, 1'b0, 16'h0800, 2'd0, 1'b1};
    rows[1] = '{1'b0, 3'b000, DEV_IP,     8'd9,  1'b0, 1'b1, 16'h0800, 2'd0, 1'b0};
    rows[2] = '{1'b0, 3'b000, FOREIGN_IP, 8'd7,  1'b0, 1'b0, 16'h0800, 2'd0, 1'b0};
    rows[3] = '{1'b0, 3'b000, DEV_IP,     8'd6,  1'b0, 1'b0, 16'h86dd, 2'd0, 1'b0};
    rows[4] = '{1'b0, 3'b000, BCAST_IP,   8'd5,  1'b0, 1'b0, 16'h0800, 2'd0, 1'b1};
    rows[5] = '{1'b1, 3'b001, PEER_IP,    8'd10, 1'b0, 1'b0, 16'h0800, 2'd1, 1'b1};
    rows[6] = '{1'b1, 3'b010, BCAST_IP,   8'd6,  1'b1, 1'b0, 16'h0800, 2'd0, 1'b1};
    rows[7] = '{1'b1, 3'b101, PEER_IP,    8'd8,  1'b0, 1'b0, 16'h0800, 2'd1, 1'b1};
    rows[8] = '{1'b1, 3'b010, PEER_IP,    8'd4,  1'b0, 1'b0, 16'h0800, 2'd2, 1'b0};
    repeat (5) @(posedge clk);
    #1;
    fsm_rst = 1'b0;
    check_eq("tx.val", 1'b0, tx.val);
    check_eq("rx_out.val", 1'b0, rx_out.val);
    check_eq("src_req", '0, src_req);
    check_eq("src_done", '0, src_done);
    for (int r = 0; r < N_ROWS; r++) begin
      if (rows[r].dir_tx)
        run_tx(r);
      else
        run_rx(r);
    end
    repeat (4) @(posedge clk);
    report_and_finish(1'b0);
  end

endmodule

//--- tb.f
hw/ipv4_pkg.sv
hw/ipv4_rx_parser.sv
hw/ipv4_tx_arbiter.sv
hw/ipv4_hdr_builder.sv
hw/ipv4_tx_framer.sv
hw/ipv4_core.sv
testbench/ipv4_core_props.sv
testbench/tb_ipv4_core.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ipv4_core -f tb.f \
  -o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
